// ==== all.f ====
+incdir+include
hw/fp_format_pkg.sv
hw/fpu_ucode_pkg.sv
hw/fpu_lzc.sv
hw/fpu_compare.sv
hw/fpu_operands.sv
hw/fpu_accumulator.sv
hw/fpu_control.sv
hw/fpu_top.sv
testbench/tb_fpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_fpu -Mdir obj_dir

output=$(./obj_dir/Vtb_fpu)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

// ==== include/fpu_model.svh ====
// FPU reference model
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// Subnormal input becomes a signed zero
function automatic logic [31:0] flush_to_zero(input logic [31:0] v);
   return (v[30:23] == 8'd0) ? {v[31], 31'b0} : v;
endfunction

// Add with 50-bit alignment and truncating normalization
function automatic logic [31:0] add_trunc(input logic [31:0] a, input logic [31:0] b,
                                          input logic sub);
   logic xs, ys;
   logic signed [8:0] xe, ye, ne;
   logic signed [49:0] xf, yf, tf;
   logic signed [50:0] s;
   int msb;
   xs = a[31];
   xe = {1'b0, a[30:23]};
   xf = (a[30:23] != 0) ? {2'b01, a[22:0], 24'd0} : '0;
   ys = b[31] ^ sub;
   ye = {1'b0, b[30:23]};
   yf = (b[30:23] != 0) ? {2'b01, b[22:0], 24'd0} : '0;
   if (ye < xe || (ye == xe && yf < xf))  // Larger magnitude into Y
      {xs, xe, xf, ys, ye, yf} = {ys, ye, yf, xs, xe, xf};
   if (xs != ys) xf = -xf;
   xf = xf >>> int'(ye - xe);
   s = yf + xf;
   msb = 0;
   for (int i = 0; i < 51; i++)
      if (s[i])
         msb = i;  // Highest set bit of the sum
   ne = ye + 9'(msb) - 9'sd47;  // Exponent once the leading one sits at bit 47
   tf = s[49:0];
   if (ne <= 0 || tf == 0) return {ys, 31'b0};
   tf = tf[48] ? (tf >> 1) : (tf << (47 - msb));
   return {ys, ne[7:0], tf[46:24]};
endfunction

// Multiply with the product truncated to 24 bits
function automatic logic [31:0] mul_trunc(input logic [31:0] a, input logic [31:0] b);
   logic [23:0] am, bm;
   logic [47:0] p, pf;
   int pe;
   am = (a[30:23] != 0) ? {1'b1, a[22:0]} : '0;
   bm = (b[30:23] != 0) ? {1'b1, b[22:0]} : '0;
   p  = am * bm;
   pf = p[47] ? p : (p << 1);
   pe = int'(a[30:23]) + int'(b[30:23]) - 127 + int'(p[47]);  // Unbiased sum rebiased
   if (pe <= 0 || p[47:46] == 2'b00) return {a[31] ^ b[31], 31'b0};
   return {a[31] ^ b[31], 8'(pe), pf[46:24]};
endfunction

// Signed order of flushed operands with -0 below +0
function automatic logic less_than(input logic [31:0] a, input logic [31:0] b);
   logic [31:0] x, y;
   x = flush_to_zero(a);
   y = flush_to_zero(b);
   if (x[31] != y[31]) return x[31];
   return x[31] ? (y[30:0] < x[30:0]) : (x[30:0] < y[30:0]);
endfunction

function automatic logic equal_to(input logic [31:0] a, input logic [31:0] b);
   return flush_to_zero(a) == flush_to_zero(b);
endfunction

function automatic logic less_equal(input logic [31:0] a, input logic [31:0] b);
   return less_than(a, b) || equal_to(a, b);
endfunction

function automatic logic [31:0] pick_min_max(input logic [31:0] a, input logic [31:0] b,
                                             input logic is_max);
   return (less_than(a, b) ^ is_max) ? flush_to_zero(a) : flush_to_zero(b);
endfunction

// Mode 0 FSGNJ, 1 FSGNJN, 2 FSGNJX, 3 FMV
function automatic logic [31:0] sign_inject(input logic [31:0] a, input logic [31:0] b,
                                            input logic [1:0] mode);
   case (mode)
      2'd0:    return {b[31], a[30:0]};
      2'd1:    return {~b[31], a[30:0]};
      2'd2:    return {a[31] ^ b[31], a[30:0]};
      default: return a;
   endcase
endfunction

`endif

// ==== testbench/tb_fpu.sv ====
// FPU random testbench
module tb_fpu;
   timeunit 1ns;
   timeprecision 1ps;

   import fp_format_pkg::*;
   import fpu_ucode_pkg::*;

   `include "fpu_model.svh"

   localparam int TOTAL_OPS       = 1 + 300 + 300 + 300 + 200 + 40;
   localparam int WATCHDOG_CYCLES = TOTAL_OPS * 10 + 1000;  // Worst op is 7 cycles
   localparam int BUSY_LIMIT      = 50;

   logic        clk = 1'b0;
   logic        rst;
   logic        wr;
   logic [31:2] instr;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic        busy;
   logic [31:0] out;

   int errors;
   int checks;
   int seed;

   fpu_top u_dut (
      .clk, .rst, .wr, .instr, .rs1, .rs2, .busy, .out
   );

   always #10 clk = ~clk;  // 20 ns period

   // RV32F OP-FP word where alt picks FMV.W.X over FMV.X.W
   function automatic logic [31:2] instr_for(input fpu_op_t op, input logic alt);
      logic [4:0]  f5;
      logic [2:0]  rm;
      logic [31:0] word;
      case (op)
         FSUB:                   f5 = 5'b00001;
         FMUL:                   f5 = 5'b00010;
         FSGNJ, FSGNJN, FSGNJX:  f5 = 5'b00100;
         FMIN, FMAX:             f5 = 5'b00101;
         FEQ, FLT, FLE:          f5 = 5'b10100;
         FMV:                    f5 = alt ? 5'b11110 : 5'b11100;
         default:                f5 = 5'b00000;  // FADD
      endcase
      case (op)  // Rounding-mode field picks the variant inside a funct5 group
         FSGNJN, FMAX, FLT:  rm = 3'b001;
         FSGNJX, FEQ:        rm = 3'b010;
         default:            rm = 3'b000;
      endcase
      word = {f5, 2'b00, 5'd2, 5'd1, rm, 5'd3, 7'b1010011};
      return word[31:2];
   endfunction

   // Busy length from the op's microprogram
   function automatic int expected_cycles(input fpu_op_t op);
      case (op)
         FADD, FSUB:                 return 5;
         FMUL:                       return 1;
         FEQ, FLT, FLE, FMIN, FMAX:  return 2;
         default:                    return 0;
      endcase
   endfunction

   function automatic logic [31:0] model_result(input fpu_op_t op, input logic [31:0] a,
                                                input logic [31:0] b);
      case (op)
         FADD:    return add_trunc(a, b, 1'b0);
         FSUB:    return add_trunc(a, b, 1'b1);
         FMUL:    return mul_trunc(a, b);
         FEQ:     return {31'b0, equal_to(a, b)};
         FLT:     return {31'b0, less_than(a, b)};
         FLE:     return {31'b0, less_equal(a, b)};
         FMIN:    return pick_min_max(a, b, 1'b0);
         FMAX:    return pick_min_max(a, b, 1'b1);
         FSGNJ:   return sign_inject(a, b, 2'd0);
         FSGNJN:  return sign_inject(a, b, 2'd1);
         FSGNJX:  return sign_inject(a, b, 2'd2);
         default: return sign_inject(a, b, 2'd3);  // FMV
      endcase
   endfunction

   // Normal float whose low range makes products underflow
   function automatic logic [31:0] rand_float(input logic low_exp);
      logic [EXP_W-1:0] e;
      e = low_exp ? EXP_W'(1 + $urandom % 63) : EXP_W'(64 + $urandom % 127);
      return {1'($urandom), e, MANT_W'($urandom)};
   endfunction

   task automatic make_pair(input logic low_exp, output logic [31:0] a, output logic [31:0] b);
      int sel;
      sel = $urandom % 10;
      a = rand_float(low_exp);
      b = rand_float(low_exp);
      case (sel)
         0: a = {a[31], 31'b0};                          // Signed zero
         1: b = {1'($urandom), 8'd0, MANT_W'($urandom)};  // Subnormal
         2: b = a;                                        // Equal
         3: b = {~a[31], a[30:0]};                        // Sign flipped
         4: b = {a[31:23], MANT_W'($urandom)};            // Same exponent for deep cancellation
         5: begin                                         // +sub against -0
            a = {1'b0, 8'd0, MANT_W'($urandom)};
            b = {1'b1, 31'b0};
         end
         default: ;
      endcase
   endtask

   // One operation from strobe to result followed by both checks
   task automatic check_op(input fpu_op_t op, input logic [31:0] a, input logic [31:0] b);
      int          cycles;
      logic [31:0] result;
      logic [31:0] expected;
      @(posedge clk);
      #2;
      instr = instr_for(op, 1'($urandom));
      rs1   = a;
      rs2   = b;
      wr    = 1'b1;
      @(posedge clk);  // Edge that samples wr
      #2;
      wr     = 1'b0;
      cycles = 0;
      while (busy === 1'b1 && cycles < BUSY_LIMIT) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      result   = out;
      expected = model_result(op, a, b);
      checks++;
      if (cycles != expected_cycles(op)) begin
         $display("%s held busy high for %0d cycles instead of %0d",
                  op.name(), cycles, expected_cycles(op));
         errors++;
      end
      if (result !== expected) begin
         $display("Mismatch at %0t: %s rs1=%h rs2=%h gave %h, expected %h",
                  $time, op.name(), a, b, result, expected);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int ops, input int errors_before);
      $display("Test %s: %0d ops, %0d errors", name, ops, errors - errors_before);
   endtask

   initial begin
      int          mark;
      logic [31:0] a;
      logic [31:0] b;
      fpu_op_t     op;
      rst    = 1'b1;
      wr     = 1'b0;
      instr  = '0;
      rs1    = '0;
      rs2    = '0;
      errors = 0;
      checks = 0;
      seed   = $urandom(40224);
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      mark = errors;  // Idle after reset and then a busy-free op
      checks++;
      if (busy !== 1'b0) begin
         $display("busy is not low after reset");
         errors++;
      end
      check_op(FSGNJ, rand_float(1'b0), rand_float(1'b0));
      report_test("reset", 1, mark);

      mark = errors;
      repeat (300) begin
         make_pair(1'b0, a, b);
         op = ($urandom % 2 == 0) ? FADD : FSUB;
         check_op(op, a, b);
      end
      report_test("add_sub", 300, mark);

      mark = errors;
      repeat (300) begin
         make_pair(($urandom % 5) == 0, a, b);  // Fifth of pairs in the underflow range
         check_op(FMUL, a, b);
      end
      report_test("mul", 300, mark);

      mark = errors;
      repeat (300) begin
         make_pair(1'b0, a, b);
         case ($urandom % 3)
            0:       op = FEQ;
            1:       op = FLT;
            default: op = FLE;
         endcase
         check_op(op, a, b);
      end
      report_test("compare", 300, mark);

      mark = errors;
      repeat (200) begin
         make_pair(1'b0, a, b);
         op = ($urandom % 2 == 0) ? FMIN : FMAX;
         check_op(op, a, b);
      end
      report_test("min_max", 200, mark);

      mark = errors;
      repeat (40) begin
         make_pair(1'b0, a, b);
         case ($urandom % 4)
            0:       op = FSGNJ;
            1:       op = FSGNJN;
            2:       op = FSGNJX;
            default: op = FMV;
         endcase
         if (op == FMV && ($urandom % 2) == 0)
            a = {1'($urandom), 8'd0, MANT_W'($urandom)};  // Subnormal must pass unchanged
         check_op(op, a, b);
      end
      report_test("sign_move", 40, mark);

      $display("Totals: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Hang guard sized from the operation count
   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("Watchdog expired before all operations finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== hw/fpu_top.sv ====
// RV32F FPU top level
module fpu_top #(
   parameter int LZC_W = 64  // Padded sum width seen by the counter
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        wr,
   input  logic [31:2] instr,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic        busy,
   output logic [31:0] out
);
   import fp_format_pkg::*;
   import fpu_ucode_pkg::*;

   uop_t    uop;
   fpu_op_t op;
   logic    a_sign, b_sign, x_sign, y_sign;
   exp_t    a_exp, b_exp;
   mant_t   a_mant, b_mant;
   wfrac_t  prod_frac, x_frac, y_frac;
   wexp_t   prod_exp, x_exp, y_exp, exp_diff;
   logic    prod_zero;
   logic    x_lt_y, x_le_y, x_eq_y, abs_y_lt_x;
   sum_t    sum;
   logic [$clog2(LZC_W)-1:0] sum_lz;

   fpu_control u_control (
      .clk, .rst, .wr, .instr, .uop, .op, .busy
   );

   fpu_operands u_operands (
      .clk, .wr, .rs1, .rs2, .a_sign, .b_sign, .a_exp, .b_exp, .a_mant, .b_mant,
      .prod_frac, .prod_exp, .prod_zero
   );

   fpu_accumulator u_accumulator (
      .clk, .wr, .uop, .op, .rs1, .rs2, .a_sign, .b_sign, .a_exp, .b_exp,
      .a_mant, .b_mant, .prod_frac, .prod_exp, .prod_zero, .x_lt_y, .x_le_y,
      .x_eq_y, .abs_y_lt_x, .exp_diff, .sum_lz, .x_sign, .y_sign, .x_exp,
      .y_exp, .x_frac, .y_frac, .sum, .out
   );

   fpu_compare u_compare (
      .x_sign, .y_sign, .x_exp, .y_exp, .x_frac, .y_frac, .exp_diff,
      .x_lt_y, .x_le_y, .x_eq_y, .abs_y_lt_x
   );

   fpu_lzc #(.W_IN(LZC_W)) u_lzc (
      .in    ({{(LZC_W - $bits(sum_t)){1'b0}}, sum}),
      .count (sum_lz)
   );

endmodule

// ==== hw/fpu_control.sv ====
// FPU decoder and micro-sequencer
module fpu_control (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   wr,     // Start strobe
   input  logic [31:2]            instr,
   output fpu_ucode_pkg::uop_t    uop,
   output fpu_ucode_pkg::fpu_op_t op,
   output logic                   busy
);
   import fpu_ucode_pkg::*;

   // ROM word, last marks the end of a microprogram
   typedef struct packed {
      logic last;
      uop_t uop;
   } uword_t;

   localparam uword_t ROM [ROM_DEPTH] = '{
      '{1'b1, READY},        // 0  idle
      '{1'b0, LOAD_XY},      // 1  FEQ FLT FLE
      '{1'b1, CMP},
      '{1'b0, LOAD_XY},      // 3  FADD FSUB
      '{1'b0, ADD_SWAP},
      '{1'b0, ADD_SHIFT},
      '{1'b0, ADD_ADD},
      '{1'b1, ADD_NORM},
      '{1'b1, LOAD_XY_MUL},  // 8  FMUL
      '{1'b0, LOAD_XY},      // 9  FMIN FMAX
      '{1'b1, MIN_MAX}
   };

   fpu_op_t dec_op;   // Decode of the instruction on the bus
   fpu_op_t op_q;     // Operation held for the running microprogram
   upc_t    start;
   upc_t    upc;
   upc_t    upc_next;
   uword_t  word;
   logic    last_q;   // Exit flag of the current word
   logic [4:0] funct5;
   logic [1:0] rm;

   assign funct5 = instr[31:27];
   assign rm     = instr[13:12];

   always_comb begin
      dec_op = NONE;
      if (instr[6:2] == 5'b10100) begin  // OP-FP major opcode
         case (funct5)
            5'b00000: dec_op = FADD;
            5'b00001: dec_op = FSUB;
            5'b00010: dec_op = FMUL;
            5'b00100: begin
               case (rm)
                  2'b00:   dec_op = FSGNJ;
                  2'b01:   dec_op = FSGNJN;
                  2'b10:   dec_op = FSGNJX;
                  default: dec_op = NONE;
               endcase
            end
            5'b00101: dec_op = instr[12] ? FMAX : FMIN;
            5'b10100: begin
               case (rm)
                  2'b10:   dec_op = FEQ;
                  2'b01:   dec_op = FLT;
                  2'b00:   dec_op = FLE;
                  default: dec_op = NONE;
               endcase
            end
            5'b11100: dec_op = (instr[14:12] == 3'b000) ? FMV : NONE;  // FMV.X.W, not FCLASS
            5'b11110: dec_op = FMV;                                    // FMV.W.X
            default:  dec_op = NONE;
         endcase
      end
   end

   always_comb begin
      case (dec_op)
         FADD, FSUB:     start = PROG_ADD;
         FMUL:           start = PROG_MUL;
         FEQ, FLT, FLE:  start = PROG_CMP;
         FMIN, FMAX:     start = PROG_MIN_MAX;
         default:        start = '0;  // Single-cycle ops stay idle
      endcase
   end

   assign upc_next = wr ? start : (last_q ? '0 : upc + 4'd1);
   assign word     = ROM[upc_next];

   always_ff @(posedge clk) begin
      if (rst) begin
         upc    <= '0;
         uop    <= READY;
         last_q <= 1'b1;  // Same as idle word
         op_q   <= NONE;
      end else begin
         upc    <= upc_next;
         uop    <= word.uop;
         last_q <= word.last;
         if (wr) op_q <= dec_op;
      end
   end

   // Decode passes straight through on the strobe cycle for single-cycle ops
   assign op   = wr ? dec_op : op_q;
   assign busy = (uop != READY);

endmodule

// ==== hw/fpu_accumulator.sv ====
// Wide X and Y registers and micro-op datapath
module fpu_accumulator (
   input  logic                   clk,
   input  logic                   wr,
   input  fpu_ucode_pkg::uop_t    uop,
   input  fpu_ucode_pkg::fpu_op_t op,
   input  logic [31:0]            rs1,
   input  logic [31:0]            rs2,
   input  logic                   a_sign,
   input  logic                   b_sign,
   input  fp_format_pkg::exp_t    a_exp,
   input  fp_format_pkg::exp_t    b_exp,
   input  fp_format_pkg::mant_t   a_mant,
   input  fp_format_pkg::mant_t   b_mant,
   input  fp_format_pkg::wfrac_t  prod_frac,
   input  fp_format_pkg::wexp_t   prod_exp,
   input  logic                   prod_zero,
   input  logic                   x_lt_y,
   input  logic                   x_le_y,
   input  logic                   x_eq_y,
   input  logic                   abs_y_lt_x,
   input  fp_format_pkg::wexp_t   exp_diff,
   input  logic [5:0]             sum_lz,
   output logic                   x_sign,
   output logic                   y_sign,
   output fp_format_pkg::wexp_t   x_exp,
   output fp_format_pkg::wexp_t   y_exp,
   output fp_format_pkg::wfrac_t  x_frac,
   output fp_format_pkg::wfrac_t  y_frac,
   output fp_format_pkg::sum_t    sum,
   output logic [31:0]            out
);
   import fp_format_pkg::*;
   import fpu_ucode_pkg::*;

   logic [5:0] norm_lshamt;  // Left shift that brings the sum to bit 47
   wexp_t      x_exp_norm;   // Exponent after that shift
   logic       cmp_bit;

   assign sum = y_frac + x_frac;  // Sign-extended to 51 bits

   assign cmp_bit = ((op == FLT) && x_lt_y) ||
                    ((op == FLE) && x_le_y) ||
                    ((op == FEQ) && x_eq_y);

   always_ff @(posedge clk) begin
      if (wr) begin
         case (op)  // Single-cycle ops land directly in the packed view of X
            FSGNJ:   {x_sign, x_exp[7:0], x_frac[46:24]} <= {rs2[31], rs1[30:0]};
            FSGNJN:  {x_sign, x_exp[7:0], x_frac[46:24]} <= {~rs2[31], rs1[30:0]};
            FSGNJX:  {x_sign, x_exp[7:0], x_frac[46:24]} <= {rs1[31] ^ rs2[31], rs1[30:0]};
            FMV:     {x_sign, x_exp[7:0], x_frac[46:24]} <= rs1;  // Raw bits, no FTZ
            default: ;
         endcase
      end else begin
         case (uop)
            LOAD_XY: begin
               x_sign <= a_sign;
               x_exp  <= {1'b0, a_exp};
               x_frac <= {2'b00, a_mant, 24'd0};
               y_sign <= b_sign ^ (op == FSUB);  // Subtract as add of negated B
               y_exp  <= {1'b0, b_exp};
               y_frac <= {2'b00, b_mant, 24'd0};
            end
            LOAD_XY_MUL: begin
               x_sign <= a_sign ^ b_sign;
               x_exp  <= prod_zero ? '0 : prod_exp;
               x_frac <= prod_zero ? '0 : prod_frac;
            end
            ADD_SWAP: begin
               if (abs_y_lt_x) begin  // Keep the larger magnitude in Y
                  x_sign <= y_sign;
                  y_sign <= x_sign;
                  x_exp  <= y_exp;
                  y_exp  <= x_exp;
                  x_frac <= (x_sign ^ y_sign) ? -y_frac : y_frac;
                  y_frac <= x_frac;
               end else if (x_sign ^ y_sign) begin
                  x_frac <= -x_frac;
               end
            end
            ADD_SHIFT: begin
               x_frac <= x_frac >>> exp_diff;  // Arithmetic, X may be negative
               x_exp  <= y_exp;
            end
            ADD_ADD: begin
               x_frac      <= sum[49:0];
               x_sign      <= y_sign;
               norm_lshamt <= sum_lz - 6'd16;  // Counter sees 13 pad bits on top
               x_exp_norm  <= x_exp + 9'sd16 - $signed({3'b000, sum_lz});
            end
            ADD_NORM: begin
               if ((x_exp_norm <= 0) || (x_frac == '0)) begin  // Underflow or exact zero
                  x_exp  <= '0;
                  x_frac <= '0;
               end else begin
                  x_exp  <= x_exp_norm;
                  x_frac <= x_frac[48] ? (x_frac >> 1) : (x_frac << norm_lshamt);
               end
            end
            CMP: {x_sign, x_exp[7:0], x_frac[46:24]} <= {31'b0, cmp_bit};
            MIN_MAX: begin
               if (x_lt_y ^ (op == FMAX))
                  {x_sign, x_exp[7:0], x_frac[46:24]} <= {x_sign, x_exp[7:0], x_frac[46:24]};
               else
                  {x_sign, x_exp[7:0], x_frac[46:24]} <= {y_sign, y_exp[7:0], y_frac[46:24]};
            end
            default: ;  // READY
         endcase
      end
   end

   assign out = {x_sign, x_exp[7:0], x_frac[46:24]};  // Top of X as a float

endmodule

// ==== hw/fpu_operands.sv ====
// Operand registers and multiplier
module fpu_operands (
   input  logic                  clk,
   input  logic                  wr,
   input  logic [31:0]           rs1,
   input  logic [31:0]           rs2,
   output logic                  a_sign,
   output logic                  b_sign,
   output fp_format_pkg::exp_t   a_exp,
   output fp_format_pkg::exp_t   b_exp,
   output fp_format_pkg::mant_t  a_mant,
   output fp_format_pkg::mant_t  b_mant,
   output fp_format_pkg::wfrac_t prod_frac,
   output fp_format_pkg::wexp_t  prod_exp,
   output logic                  prod_zero
);
   import fp_format_pkg::*;

   logic [2*MANT_W+1:0] prod;  // Raw 48-bit mantissa product

   always_ff @(posedge clk) begin
      if (wr) begin
         a_sign <= rs1[31];
         a_exp  <= rs1[MANT_W +: EXP_W];
         a_mant <= (rs1[MANT_W +: EXP_W] != '0) ? {1'b1, rs1[MANT_W-1:0]} : '0;  // FTZ
         b_sign <= rs2[31];
         b_exp  <= rs2[MANT_W +: EXP_W];
         b_mant <= (rs2[MANT_W +: EXP_W] != '0) ? {1'b1, rs2[MANT_W-1:0]} : '0;
      end
   end

   assign prod = a_mant * b_mant;

   // Leading one is at bit 47 or 46 for normal inputs
   assign prod_frac = prod[LEAD_BIT] ? {2'b00, prod} : {2'b00, prod[LEAD_BIT-1:0], 1'b0};

   // Sum of biased exponents, rebiased, bumped when the product carries
   assign prod_exp = wexp_t'({1'b0, a_exp} + {1'b0, b_exp} - 9'(EXP_BIAS)
                             + {8'b0, prod[LEAD_BIT]});

   // Zero operand or underflow
   assign prod_zero = (prod_exp <= 0) || (prod[LEAD_BIT -: 2] == 2'b00);

endmodule

// ==== hw/fpu_compare.sv ====
// X against Y comparator
module fpu_compare (
   input  logic                  x_sign,
   input  logic                  y_sign,
   input  fp_format_pkg::wexp_t  x_exp,
   input  fp_format_pkg::wexp_t  y_exp,
   input  fp_format_pkg::wfrac_t x_frac,
   input  fp_format_pkg::wfrac_t y_frac,
   output fp_format_pkg::wexp_t  exp_diff,
   output logic                  x_lt_y,
   output logic                  x_le_y,
   output logic                  x_eq_y,
   output logic                  abs_y_lt_x
);
   import fp_format_pkg::*;

   sum_t frac_diff;
   logic exp_eq;
   logic frac_eq;
   logic abs_eq;
   logic abs_x_lt_y;
   logic abs_x_le_y;
   logic abs_y_le_x;

   assign exp_diff  = y_exp - x_exp;  // Also the alignment shift
   assign frac_diff = y_frac - x_frac;

   assign exp_eq  = (exp_diff == '0);
   assign frac_eq = (frac_diff == '0);
   assign abs_eq  = exp_eq && frac_eq;

   // Magnitude order, exponent first
   assign abs_x_lt_y = (!exp_diff[8] && !exp_eq) || (exp_eq && !frac_eq && !frac_diff[50]);
   assign abs_x_le_y = (!exp_diff[8] && !exp_eq) || (exp_eq && !frac_diff[50]);
   assign abs_y_lt_x = exp_diff[8] || (exp_eq && frac_diff[50]);
   assign abs_y_le_x = abs_y_lt_x || abs_eq;

   // Signed order, negative magnitudes reversed
   assign x_lt_y = (x_sign && !y_sign) || (x_sign && y_sign && abs_y_lt_x) ||
                   (!x_sign && !y_sign && abs_x_lt_y);
   assign x_le_y = (x_sign && !y_sign) || (x_sign && y_sign && abs_y_le_x) ||
                   (!x_sign && !y_sign && abs_x_le_y);
   assign x_eq_y = abs_eq && (x_sign == y_sign);

endmodule

// ==== hw/fpu_lzc.sv ====
// Recursive leading-zero counter
module fpu_lzc #(
   parameter int W_IN = 64  // Power of two, 2 or more
) (
   input  logic [W_IN-1:0]         in,
   output logic [$clog2(W_IN)-1:0] count
);

   generate
      if (W_IN == 2) begin : g_leaf
         assign count = ~in[1];
      end else begin : g_node
         logic [$clog2(W_IN)-2:0] half_count;
         logic                    upper_empty;

         assign upper_empty = ~|in[W_IN-1 -: W_IN/2];

         fpu_lzc #(.W_IN(W_IN/2)) u_half (
            .in    (upper_empty ? in[W_IN/2-1:0] : in[W_IN-1 -: W_IN/2]),
            .count (half_count)
         );

         assign count = {upper_empty, half_count};  // Empty top half adds W_IN/2
      end
   endgenerate

endmodule

// ==== hw/fpu_ucode_pkg.sv ====
// Microcode and operation encodings
package fpu_ucode_pkg;

   // Micro-ops executed by the accumulator
   typedef enum logic [3:0] {
      READY,        // Idle, no datapath update
      LOAD_XY,      // X <- A, Y <- B
      LOAD_XY_MUL,  // X <- norm(A*B)
      ADD_SWAP,     // Larger magnitude to Y, negate X on sign mismatch
      ADD_SHIFT,    // Align X to exponent of Y
      ADD_ADD,      // X <- X + Y, latch normalization amount
      ADD_NORM,     // Normalize X, flush underflow
      CMP,          // X <- FEQ/FLT/FLE result
      MIN_MAX       // X <- X or Y
   } uop_t;

   typedef logic [3:0] upc_t;

   // Decoded RV32F operation
   typedef enum logic [3:0] {
      NONE,
      FADD,
      FSUB,
      FMUL,
      FEQ,
      FLT,
      FLE,
      FMIN,
      FMAX,
      FSGNJ,
      FSGNJN,
      FSGNJX,
      FMV     // Both FMV.X.W and FMV.W.X
   } fpu_op_t;

   // Microprogram entry points, word 0 is the idle word
   localparam upc_t PROG_CMP     = 4'd1;
   localparam upc_t PROG_ADD     = 4'd3;
   localparam upc_t PROG_MUL     = 4'd8;
   localparam upc_t PROG_MIN_MAX = 4'd9;
   localparam int   ROM_DEPTH    = 11;

endpackage

// ==== hw/fp_format_pkg.sv ====
// Single-precision format definitions
package fp_format_pkg;

   localparam int EXP_W    = 8;   // Biased exponent field
   localparam int MANT_W   = 23;  // Stored fraction field
   localparam int EXP_BIAS = 127;
   localparam int LEAD_BIT = 47;  // Leading one of a normalized wide fraction

   // Fields of an unpacked operand
   typedef logic [EXP_W-1:0] exp_t;
   typedef logic [MANT_W:0]  mant_t;  // Hidden bit on top

   // Wide internal format of X and Y
   // Value is +/- frac * 2^(exp - bias - 47)
   typedef logic signed [EXP_W:0] wexp_t;
   typedef logic signed [49:0]    wfrac_t;  // Two guard bits above the leading bit

   // One extra bit so the sign of a difference survives
   typedef logic signed [50:0] sum_t;

endpackage
